// File: verilog/stm_params.svh
// STM parameters for data widths, FIFO depth and module identity
`ifndef STM_PARAMS_SVH
`define STM_PARAMS_SVH

// Trace payload and timestamp widths
`define STM_VALUE_WIDTH 64
`define STM_TS_WIDTH 32

// Event buffer entries
`define STM_FIFO_DEPTH 8

// Identity registers, read-only at 0x0000 to 0x0002
`define STM_MOD_VENDOR 16'h1
`define STM_MOD_TYPE 16'h4
`define STM_MOD_VERSION 16'h0

`endif

// File: verilog/stm_pkg.sv
// STM package with data types, packet type codes and FSM state encodings
`include "stm_params.svh"

package stm_pkg;

   typedef logic [15:0] dii_word_t;
   typedef logic [`STM_TS_WIDTH-1:0] timestamp_t;
   typedef logic [15:0] trace_id_t;
   typedef logic [`STM_VALUE_WIDTH-1:0] trace_value_t;
   typedef logic [15:0] reg_addr_t;

   // One buffered record, id carries the drop count when overflow is set
   typedef struct packed {
      logic         overflow;
      trace_value_t value;
      trace_id_t    id;
      timestamp_t   timestamp;
   } stm_event_t;

   // Packet type, bits 15:14 of the flags word
   localparam logic [1:0] TYPE_REG   = 2'd0;
   localparam logic [1:0] TYPE_EVENT = 2'd2;

   // Subtypes, bits 13:10 of the flags word
   localparam logic [3:0] REQ_READ       = 4'b0000;
   localparam logic [3:0] REQ_WRITE      = 4'b0100;
   localparam logic [3:0] RESP_READ      = 4'b1000;
   localparam logic [3:0] RESP_READ_ERR  = 4'b1100;
   localparam logic [3:0] RESP_WRITE     = 4'b1110;
   localparam logic [3:0] RESP_WRITE_ERR = 4'b1111;
   localparam logic [3:0] EV_TRACE       = 4'b0000;
   localparam logic [3:0] EV_OVERFLOW    = 4'b0101;

   typedef enum logic [3:0] {
      RA_DEST, RA_SRC, RA_FLAGS, RA_ADDR, RA_WDATA, RA_EXEC,
      RA_RESP_DEST, RA_RESP_SRC, RA_RESP_FLAGS, RA_RESP_DATA
   } regacc_state_t;

   typedef enum logic [3:0] {
      PK_DEST, PK_SRC, PK_FLAGS, PK_TS_LO, PK_TS_HI, PK_ID,
      PK_VAL0, PK_VAL1, PK_VAL2, PK_VAL3, PK_OVF
   } pkt_state_t;

endpackage

// File: verilog/dii_if.sv
// Debug interconnect flit channel with valid/ready handshake
interface dii_if;
   import stm_pkg::*;

   dii_word_t data;
   logic      last;
   logic      valid;
   logic      ready;

   // Producer side of the channel
   modport source (
      output data, last, valid,
      input  ready
   );

   // Consumer side of the channel
   modport sink (
      input  data, last, valid,
      output ready
   );

endinterface

// File: verilog/stm_regaccess.sv
// STM register access layer, answers host requests and merges responses with events
`include "stm_params.svh"

module stm_regaccess (
   input  logic               clk,
   input  logic               rst_n,
   input  stm_pkg::dii_word_t id,
   dii_if.sink                debug_in,
   dii_if.sink                event_in,
   dii_if.source              debug_out,
   output logic               enable,
   output stm_pkg::dii_word_t event_dest
);
   import stm_pkg::*;

   regacc_state_t state;
   dii_word_t     req_src;
   logic [3:0]    req_subtype;
   reg_addr_t     req_addr;
   dii_word_t     req_wdata;
   logic          req_has_data;
   logic          is_write;
   dii_word_t     rd_data;
   logic          rd_err;
   logic          wr_err;
   logic          resp_write;
   logic          resp_err;
   dii_word_t     resp_data;
   logic [3:0]    resp_subtype;
   logic          resp_valid;
   dii_word_t     resp_word;
   logic          resp_last;
   logic          resp_ready;
   logic          in_xfer;
   logic          arb_busy;
   logic          arb_resp;

   // Requests are taken only while no response is pending
   assign debug_in.ready = state inside {RA_DEST, RA_SRC, RA_FLAGS, RA_ADDR, RA_WDATA};
   assign in_xfer = debug_in.valid & debug_in.ready;
   assign is_write = (req_subtype == REQ_WRITE);

   always_comb begin
      rd_data = '0;
      rd_err  = 1'b0;
      case (req_addr)
         16'h0000: rd_data = `STM_MOD_VENDOR;
         16'h0001: rd_data = `STM_MOD_TYPE;
         16'h0002: rd_data = `STM_MOD_VERSION;
         16'h0003: rd_data = {15'h0, enable};
         16'h0004: rd_data = event_dest;
         16'h0200: rd_data = 16'(`STM_VALUE_WIDTH);
         default:  rd_err = 1'b1;
      endcase
      // Only control and event_dest are writable, and a write needs its data word
      wr_err = !(req_addr inside {16'h0003, 16'h0004}) || !req_has_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= RA_DEST;
         enable     <= 1'b0;
         event_dest <= '0;
      end else begin
         case (state)
            RA_DEST:       if (in_xfer && !debug_in.last) state <= RA_SRC;
            RA_SRC:        if (in_xfer) state <= debug_in.last ? RA_DEST : RA_FLAGS;
            RA_FLAGS:      if (in_xfer) state <= debug_in.last ? RA_DEST : RA_ADDR;
            RA_ADDR:       if (in_xfer) state <= debug_in.last ? RA_EXEC : RA_WDATA;
            RA_WDATA:      if (in_xfer) state <= RA_EXEC;
            RA_EXEC: begin
               if (is_write && !wr_err) begin
                  if (req_addr == 16'h0003)
                     enable <= req_wdata[0];
                  else
                     event_dest <= req_wdata;
               end
               state <= RA_RESP_DEST;
            end
            RA_RESP_DEST:  if (resp_ready) state <= RA_RESP_SRC;
            RA_RESP_SRC:   if (resp_ready) state <= RA_RESP_FLAGS;
            RA_RESP_FLAGS: if (resp_ready) state <= resp_last ? RA_DEST : RA_RESP_DATA;
            RA_RESP_DATA:  if (resp_ready) state <= RA_DEST;
            default:       state <= RA_DEST;
         endcase
      end
   end

   // Request fields and latched decode result
   always_ff @(posedge clk) begin
      if (in_xfer) begin
         case (state)
            RA_SRC:   req_src <= debug_in.data;
            RA_FLAGS: req_subtype <= debug_in.data[13:10];
            RA_ADDR: begin
               req_addr     <= debug_in.data;
               req_has_data <= 1'b0;
            end
            RA_WDATA: begin
               req_wdata    <= debug_in.data;
               req_has_data <= 1'b1;
            end
            default: ;
         endcase
      end
      if (state == RA_EXEC) begin
         resp_write <= is_write;
         resp_err   <= is_write ? wr_err : rd_err;
         resp_data  <= rd_data;
      end
   end

   assign resp_subtype = resp_write ? (resp_err ? RESP_WRITE_ERR : RESP_WRITE)
                                    : (resp_err ? RESP_READ_ERR : RESP_READ);
   assign resp_valid = state inside {RA_RESP_DEST, RA_RESP_SRC, RA_RESP_FLAGS, RA_RESP_DATA};
   assign resp_ready = arb_busy & arb_resp & debug_out.ready;

   always_comb begin
      resp_word = resp_data;
      resp_last = 1'b1;
      case (state)
         RA_RESP_DEST: begin
            resp_word = req_src;
            resp_last = 1'b0;
         end
         RA_RESP_SRC: begin
            resp_word = id;
            resp_last = 1'b0;
         end
         RA_RESP_FLAGS: begin
            resp_word = {TYPE_REG, resp_subtype, 10'h0};
            // Errors and write acks have no payload
            resp_last = resp_write | resp_err;
         end
         default: ;
      endcase
   end

   // Packet boundary arbiter, a pending response wins over the next event
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arb_busy <= 1'b0;
         arb_resp <= 1'b0;
      end else if (!arb_busy) begin
         if (resp_valid || event_in.valid) begin
            arb_busy <= 1'b1;
            arb_resp <= resp_valid;
         end
      end else if (debug_out.valid && debug_out.ready && debug_out.last) begin
         arb_busy <= 1'b0;
      end
   end

   assign debug_out.valid = arb_busy & (arb_resp ? resp_valid : event_in.valid);
   assign debug_out.data  = arb_resp ? resp_word : event_in.data;
   assign debug_out.last  = arb_resp ? resp_last : event_in.last;
   assign event_in.ready  = arb_busy & !arb_resp & debug_out.ready;

   a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (debug_out.valid && !debug_out.ready) |=> (debug_out.valid && $stable(debug_out.data)))
      else $error("debug_out changed while stalled");

   // Address plus write data is the longest request payload
   a_req_len: assert property (@(posedge clk) disable iff (!rst_n)
      (state == RA_WDATA && debug_in.valid) |-> debug_in.last)
      else $error("register request with more than two payload words");

endmodule

// File: verilog/stm_trace_sample.sv
// STM trace sampler, stamps trace points and turns dropped samples into overflow records
module stm_trace_sample (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enable,
   input  logic                  trace_valid,
   input  stm_pkg::trace_id_t    trace_id,
   input  stm_pkg::trace_value_t trace_value,
   input  logic                  out_ready,
   output stm_pkg::stm_event_t   out_data,
   output logic                  out_valid
);
   import stm_pkg::*;

   timestamp_t timestamp;
   trace_id_t  drop_count;
   logic       sample;
   logic       slot_free;

   assign sample    = trace_valid & enable;
   assign slot_free = !out_valid | out_ready;

   // Free running time base
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         timestamp <= '0;
      else
         timestamp <= timestamp + 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         drop_count <= '0;
      end else if (slot_free) begin
         out_valid <= sample || (drop_count != '0);
         // Slot goes to the overflow record, so a sample here is lost too
         if (drop_count != '0)
            drop_count <= {15'h0, sample};
      end else if (sample && drop_count != 16'hffff) begin
         drop_count <= drop_count + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (slot_free) begin
         if (drop_count != '0)
            out_data <= '{overflow: 1'b1, value: '0, id: drop_count, timestamp: timestamp};
         else
            out_data <= '{overflow: 1'b0, value: trace_value, id: trace_id,
                          timestamp: timestamp};
      end
   end

   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
      else $error("sample record changed while stalled");

endmodule

// File: verilog/stm_fifo.sv
// Synchronous FIFO with circular buffer and fill count
module stm_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 8
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [WIDTH-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [AW:0]      count;
   logic             wr_en;
   logic             rd_en;

   assign in_ready  = (count != (AW+1)'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];
   assign wr_en     = in_valid & in_ready;
   assign rd_en     = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= in_data;
   end

   // Pointers wrap at DEPTH, which need not be a power of two
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + {{AW{1'b0}}, wr_en} - {{AW{1'b0}}, rd_en};
      end
   end

   // A write at full or a read at empty would push the fill count out of range
   a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
      (count == (AW+1)'(DEPTH)) |=> (count != (AW+1)'(DEPTH + 1)))
      else $error("FIFO written while full");

   a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
      (count == '0) |=> (count <= (AW+1)'(1)))
      else $error("FIFO read while empty");

endmodule

// File: verilog/stm_packetizer.sv
// STM packetizer, turns trace and overflow records into event packets
module stm_packetizer (
   input  logic                clk,
   input  logic                rst_n,
   input  stm_pkg::dii_word_t  id,
   input  stm_pkg::dii_word_t  event_dest,
   input  stm_pkg::stm_event_t in_data,
   input  logic                in_valid,
   output logic                in_ready,
   dii_if.source               debug_out
);
   import stm_pkg::*;

   pkt_state_t state;
   logic       xfer;

   // The record stays at the FIFO head until its last word is sent
   assign debug_out.valid = in_valid;
   assign xfer     = debug_out.valid & debug_out.ready;
   assign in_ready = xfer & debug_out.last;

   always_comb begin
      debug_out.last = 1'b0;
      case (state)
         PK_DEST:  debug_out.data = event_dest;
         PK_SRC:   debug_out.data = id;
         PK_FLAGS: debug_out.data = {TYPE_EVENT, in_data.overflow ? EV_OVERFLOW : EV_TRACE, 10'h0};
         PK_TS_LO: debug_out.data = in_data.timestamp[15:0];
         PK_TS_HI: debug_out.data = in_data.timestamp[31:16];
         PK_ID:    debug_out.data = in_data.id;
         PK_VAL0:  debug_out.data = in_data.value[15:0];
         PK_VAL1:  debug_out.data = in_data.value[31:16];
         PK_VAL2:  debug_out.data = in_data.value[47:32];
         PK_VAL3: begin
            debug_out.data = in_data.value[63:48];
            debug_out.last = 1'b1;
         end
         PK_OVF: begin
            // Drop count travels in the id field
            debug_out.data = in_data.id;
            debug_out.last = 1'b1;
         end
         default:  debug_out.data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= PK_DEST;
      end else if (xfer) begin
         case (state)
            PK_DEST:  state <= PK_SRC;
            PK_SRC:   state <= PK_FLAGS;
            PK_FLAGS: state <= in_data.overflow ? PK_OVF : PK_TS_LO;
            PK_TS_LO: state <= PK_TS_HI;
            PK_TS_HI: state <= PK_ID;
            PK_ID:    state <= PK_VAL0;
            PK_VAL0:  state <= PK_VAL1;
            PK_VAL1:  state <= PK_VAL2;
            PK_VAL2:  state <= PK_VAL3;
            default:  state <= PK_DEST;
         endcase
      end
   end

   a_last_final: assert property (@(posedge clk) disable iff (!rst_n)
      (debug_out.valid && debug_out.last) |->
         (in_data.overflow ? (state == PK_OVF) : (state == PK_VAL3)))
      else $error("last outside the final payload word");

endmodule

// File: verilog/stm_top.sv
// STM top level, maps the debug ports onto channels and connects the trace path
`include "stm_params.svh"

module stm_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  stm_pkg::dii_word_t    id,
   input  stm_pkg::dii_word_t    debug_in_data,
   input  logic                  debug_in_last,
   input  logic                  debug_in_valid,
   output logic                  debug_in_ready,
   output stm_pkg::dii_word_t    debug_out_data,
   output logic                  debug_out_last,
   output logic                  debug_out_valid,
   input  logic                  debug_out_ready,
   input  logic                  trace_valid,
   input  stm_pkg::trace_id_t    trace_id,
   input  stm_pkg::trace_value_t trace_value
);
   import stm_pkg::*;

   dii_if dbg_in ();
   dii_if evt ();
   dii_if dbg_out ();

   logic       enable;
   dii_word_t  event_dest;
   stm_event_t sample_data;
   logic       sample_valid;
   logic       sample_ready;
   stm_event_t pkt_data;
   logic       pkt_valid;
   logic       pkt_ready;

   assign dbg_in.data      = debug_in_data;
   assign dbg_in.last      = debug_in_last;
   assign dbg_in.valid     = debug_in_valid;
   assign debug_in_ready   = dbg_in.ready;
   assign debug_out_data   = dbg_out.data;
   assign debug_out_last   = dbg_out.last;
   assign debug_out_valid  = dbg_out.valid;
   assign dbg_out.ready    = debug_out_ready;

   stm_regaccess u_regaccess (
      .clk        (clk),
      .rst_n      (rst_n),
      .id         (id),
      .debug_in   (dbg_in.sink),
      .event_in   (evt.sink),
      .debug_out  (dbg_out.source),
      .enable     (enable),
      .event_dest (event_dest)
   );

   stm_trace_sample u_sample (
      .clk         (clk),
      .rst_n       (rst_n),
      .enable      (enable),
      .trace_valid (trace_valid),
      .trace_id    (trace_id),
      .trace_value (trace_value),
      .out_ready   (sample_ready),
      .out_data    (sample_data),
      .out_valid   (sample_valid)
   );

   stm_fifo #(
      .WIDTH ($bits(stm_event_t)),
      .DEPTH (`STM_FIFO_DEPTH)
   ) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_data   (sample_data),
      .in_valid  (sample_valid),
      .in_ready  (sample_ready),
      .out_data  (pkt_data),
      .out_valid (pkt_valid),
      .out_ready (pkt_ready)
   );

   stm_packetizer u_packetizer (
      .clk        (clk),
      .rst_n      (rst_n),
      .id         (id),
      .event_dest (event_dest),
      .in_data    (pkt_data),
      .in_valid   (pkt_valid),
      .in_ready   (pkt_ready),
      .debug_out  (evt.source)
   );

endmodule

// File: test/stm_tb.sv
// STM testbench that replays golden commands against the trace module and checks its packets
`include "stm_params.svh"

module stm_tb;
   import stm_pkg::*;

   localparam int        TIMEOUT   = 1000;
   localparam int        MAX_WORDS = 11;
   localparam dii_word_t DUT_ID    = 16'h0042;

   logic         clk;
   logic         rst_n;
   dii_word_t    debug_in_data;
   logic         debug_in_last;
   logic         debug_in_valid;
   logic         debug_in_ready;
   dii_word_t    debug_out_data;
   logic         debug_out_last;
   logic         debug_out_valid;
   logic         debug_out_ready;
   logic         trace_valid;
   trace_id_t    trace_id;
   trace_value_t trace_value;

   logic [31:0]  lfsr = 32'h1007;
   logic         hold_ready_low = 1'b0;
   dii_word_t    next_src = 16'h0100;
   dii_word_t    cur_dest = '0;
   logic         enabled = 1'b0;
   timestamp_t   last_ts = '0;
   int           since_check = 0;

   // Expected event packets in arrival order
   logic         exp_ovf[$];
   dii_word_t    exp_id[$];
   trace_value_t exp_val[$];
   dii_word_t    exp_dest[$];

   // Packets assembled from debug_out
   dii_word_t    rx_words[$];
   int           rx_len[$];
   dii_word_t    cur_pkt[$];
   logic         stalled = 1'b0;
   dii_word_t    held_data;

   stm_top u_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .id              (DUT_ID),
      .debug_in_data   (debug_in_data),
      .debug_in_last   (debug_in_last),
      .debug_in_valid  (debug_in_valid),
      .debug_in_ready  (debug_in_ready),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready),
      .trace_valid     (trace_valid),
      .trace_id        (trace_id),
      .trace_value     (trace_value)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [63:0] rand_bits(int n);
      logic [63:0] r;
      logic        fb;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[62:0], fb};
      end
      return r;
   endfunction

   function automatic bit has_err(string s);
      int i;
      for (i = 0; i + 3 <= s.len(); i++) begin
         if (s.substr(i, i + 2) == "ERR")
            return 1'b1;
      end
      return 1'b0;
   endfunction

   task automatic fail(string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check(string name, logic [63:0] got, logic [63:0] exp);
      if (got !== exp)
         fail($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Output back-pressure is random unless a stall burst holds it low
   initial begin
      logic [63:0] r;
      debug_out_ready = 1'b0;
      forever begin
         next_cycle();
         r = rand_bits(1);
         debug_out_ready = hold_ready_low ? 1'b0 : r[0];
      end
   end

   // Collects packets and checks that a stalled word is held
   always @(negedge clk) begin
      if (rst_n) begin
         if (stalled) begin
            check("debug_out_valid", debug_out_valid, 1'b1);
            check("debug_out_data", debug_out_data, held_data);
         end
         if (debug_out_valid && debug_out_ready) begin
            cur_pkt.push_back(debug_out_data);
            if (cur_pkt.size() > MAX_WORDS)
               fail("packet on debug_out runs past eleven words");
            if (debug_out_last) begin
               rx_len.push_back(cur_pkt.size());
               foreach (cur_pkt[i])
                  rx_words.push_back(cur_pkt[i]);
               cur_pkt.delete();
            end
         end
         stalled   = debug_out_valid && !debug_out_ready;
         held_data = debug_out_data;
      end
   end

   task automatic send_word(dii_word_t data, logic last);
      bit done;
      int n;
      done           = 1'b0;
      debug_in_data  = data;
      debug_in_last  = last;
      debug_in_valid = 1'b1;
      for (n = 0; n < TIMEOUT && !done; n++) begin
         @(negedge clk);
         done = debug_in_ready;
         next_cycle();
      end
      if (!done)
         fail("debug_in_ready stayed low, request word not accepted");
      debug_in_valid = 1'b0;
   endtask

   task automatic receive_packet(output dii_word_t pkt[MAX_WORDS], output int len);
      int n;
      n = 0;
      while (rx_len.size() == 0 && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      if (rx_len.size() == 0)
         fail("no packet arrived on debug_out before the timeout");
      len = rx_len.pop_front();
      for (n = 0; n < len; n++)
         pkt[n] = rx_words.pop_front();
      if (len < 3)
         fail("packet on debug_out is shorter than its header");
   endtask

   task automatic expect_event(logic ovf, dii_word_t tid, trace_value_t val);
      exp_ovf.push_back(ovf);
      exp_id.push_back(tid);
      exp_val.push_back(val);
      exp_dest.push_back(cur_dest);
      since_check++;
   endtask

   task automatic check_event(dii_word_t pkt[MAX_WORDS], int len);
      logic ovf;
      if (exp_ovf.size() == 0)
         fail("event packet arrived that no trace point caused");
      ovf = exp_ovf.pop_front();
      check("event dest", pkt[0], exp_dest.pop_front());
      check("event source", pkt[1], DUT_ID);
      check("event flags", pkt[2], {TYPE_EVENT, ovf ? EV_OVERFLOW : EV_TRACE, 10'h0});
      if (ovf) begin
         check("overflow length", len, 4);
         check("overflow count", pkt[3], exp_id.pop_front());
         void'(exp_val.pop_front());
      end else begin
         check("trace length", len, 10);
         if ({pkt[4], pkt[3]} <= last_ts)
            fail("trace timestamps do not increase");
         last_ts = {pkt[4], pkt[3]};
         check("trace id", pkt[5], exp_id.pop_front());
         check("trace value", {pkt[9], pkt[8], pkt[7], pkt[6]}, exp_val.pop_front());
      end
   endtask

   task automatic reg_access(logic write, reg_addr_t addr, dii_word_t wdata, logic err,
                             dii_word_t rdata);
      dii_word_t  pkt[MAX_WORDS];
      int         len;
      int         n;
      bit         got;
      logic [3:0] sub;
      dii_word_t  src;
      src = next_src;
      next_src++;
      send_word(DUT_ID, 1'b0);
      send_word(src, 1'b0);
      send_word({TYPE_REG, write ? REQ_WRITE : REQ_READ, 10'h0}, 1'b0);
      send_word(addr, !write);
      if (write)
         send_word(wdata, 1'b1);
      // No new request is taken while the response is pending
      @(negedge clk);
      check("debug_in_ready", debug_in_ready, 1'b0);
      // Event packets may come ahead of the response
      got = 1'b0;
      for (n = 0; n < 64 && !got; n++) begin
         receive_packet(pkt, len);
         if (pkt[2][15:14] == TYPE_REG)
            got = 1'b1;
         else
            check_event(pkt, len);
      end
      if (!got)
         fail("no register response among the received packets");
      if (write)
         sub = err ? RESP_WRITE_ERR : RESP_WRITE;
      else
         sub = err ? RESP_READ_ERR : RESP_READ;
      check("response dest", pkt[0], src);
      check("response source", pkt[1], DUT_ID);
      check("response flags", pkt[2], {TYPE_REG, sub, 10'h0});
      if (write || err) begin
         check("response length", len, 3);
      end else begin
         check("response length", len, 4);
         check("read data", pkt[3], rdata);
      end
      if (write && !err && addr == 16'h0003)
         enabled = wdata[0];
      if (write && !err && addr == 16'h0004)
         cur_dest = wdata;
   endtask

   task automatic trace_point(trace_id_t tid, trace_value_t val);
      trace_valid = 1'b1;
      trace_id    = tid;
      trace_value = val;
      next_cycle();
      trace_valid = 1'b0;
      if (enabled)
         expect_event(1'b0, tid, val);
   endtask

   task automatic stall_burst(int count);
      trace_id_t    tid;
      trace_value_t val;
      int           keep;
      int           n;
      // FIFO entries plus the sampler's output register get through
      keep = `STM_FIFO_DEPTH + 1;
      hold_ready_low = 1'b1;
      next_cycle();
      next_cycle();
      for (n = 0; n < count; n++) begin
         tid         = trace_id_t'(rand_bits(16));
         val         = rand_bits(64);
         trace_valid = 1'b1;
         trace_id    = tid;
         trace_value = val;
         if (enabled && n < keep)
            expect_event(1'b0, tid, val);
         next_cycle();
      end
      trace_valid = 1'b0;
      if (enabled && count > keep)
         expect_event(1'b1, dii_word_t'(count - keep), '0);
      next_cycle();
      hold_ready_low = 1'b0;
   endtask

   task automatic expect_events(int count);
      dii_word_t pkt[MAX_WORDS];
      int        len;
      int        n;
      check("expected event count", since_check, count);
      since_check = 0;
      while (exp_ovf.size() > 0) begin
         receive_packet(pkt, len);
         if (pkt[2][15:14] != TYPE_EVENT)
            fail("register response arrived without a request");
         check_event(pkt, len);
      end
      // Output stays quiet once all expected events are in
      for (n = 0; n < 40; n++) begin
         @(negedge clk);
         if (debug_out_valid || rx_len.size() != 0)
            fail("unexpected packet on debug_out");
      end
      next_cycle();
   endtask

   initial begin
      int          fd;
      string       line;
      byte         cmd;
      logic [63:0] a;
      logic [63:0] b;
      int          count;
      rst_n          = 1'b0;
      debug_in_data  = '0;
      debug_in_last  = 1'b0;
      debug_in_valid = 1'b0;
      trace_valid    = 1'b0;
      trace_id       = '0;
      trace_value    = '0;
      a              = '0;
      b              = '0;
      count          = 0;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      // Idle state right after reset
      @(negedge clk);
      check("debug_in_ready", debug_in_ready, 1'b1);
      check("debug_out_valid", debug_out_valid, 1'b0);
      next_cycle();
      fd = $fopen("test/stm_golden.txt", "r");
      if (fd == 0)
         fail("cannot open test/stm_golden.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 3)
            continue;
         cmd = line.getc(0);
         if (cmd == "#")
            continue;
         void'($sscanf(line.substr(2, line.len() - 1), "%h %h", a, b));
         void'($sscanf(line.substr(2, line.len() - 1), "%d", count));
         case (cmd)
            "R":     reg_access(1'b0, a[15:0], '0, has_err(line), b[15:0]);
            "W":     reg_access(1'b1, a[15:0], b[15:0], has_err(line), '0);
            "T":     trace_point(a[15:0], b);
            "S":     stall_burst(count);
            "E":     expect_events(count);
            default: fail("unknown command in the golden file");
         endcase
      end
      $fclose(fd);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: build.f
+incdir+verilog
verilog/stm_pkg.sv
verilog/dii_if.sv
verilog/stm_regaccess.sv
verilog/stm_trace_sample.sv
verilog/stm_fifo.sv
verilog/stm_packetizer.sv
verilog/stm_top.sv
test/stm_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = stm_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/stm_golden.txt
# R: addr, expected data or ERR    W: addr, data, OK or ERR
# T: id, value    S: sample count    E: event packets expected since the previous E
R 0000 0001
R 0001 0004
R 0002 0000
R 0200 0040
R 0005 ERR
R 1234 ERR
W 0000 1234 ERR
W 0200 0020 ERR
W 0004 00a5 OK
R 0004 00a5
R 0003 0000
T 0011 0000000000000001
T 0012 0000000000000002
E 0
W 0003 0001 OK
R 0003 0001
T 0021 1122334455667788
T 0022 deadbeefcafef00d
T 0023 0123456789abcdef
E 3
S 14
E 10
W 0004 0033 OK
T 0031 aaaa5555aaaa5555
R 0001 0004
T 0032 0f0f0f0f0f0f0f0f
W 0200 0001 ERR
T 0033 8000000000000001
W 0003 0001 OK
R 0300 ERR
T 0034 00000000ffffffff
E 4
W 0003 0000 OK
T 0041 5555aaaa5555aaaa
E 0
R 0003 0000
